// ==== common/lvdcPkg.sv ====
package lvdcPkg;

    localparam int WordWidth     = 26;
    localparam int SyllableWidth = 13;
    localparam int OpWidth       = 4;
    localparam int AddrWidth     = 9;
    localparam int MemDepth      = 512;
    localparam int BitCountWidth = 5;
    localparam int SylCountWidth = 4;  // counts 0..12 while a syllable assembles
    localparam int FnWidth       = 2;

    localparam logic [BitCountWidth-1:0] LastBit = BitCountWidth'(WordWidth - 1);

    // kept op codes
    localparam logic [OpWidth-1:0] OpSub = 4'b0010;
    localparam logic [OpWidth-1:0] OpAnd = 4'b0110;
    localparam logic [OpWidth-1:0] OpAdd = 4'b0111;
    localparam logic [OpWidth-1:0] OpXor = 4'b1001;
    localparam logic [OpWidth-1:0] OpSto = 4'b1011;
    localparam logic [OpWidth-1:0] OpRsu = 4'b1101;
    localparam logic [OpWidth-1:0] OpCla = 4'b1111;

    // serial alu function select
    localparam logic [FnWidth-1:0] FnSum  = 2'd0;
    localparam logic [FnWidth-1:0] FnAnd  = 2'd1;
    localparam logic [FnWidth-1:0] FnXor  = 2'd2;
    localparam logic [FnWidth-1:0] FnPass = 2'd3;

    typedef logic [WordWidth-1:0] word_t;

    typedef struct packed {
        logic [OpWidth-1:0]   opCode;
        logic [AddrWidth-1:0] addr;
    } syllable_t;

    typedef struct packed {
        logic [FnWidth-1:0] fn;
        logic               invAcc;
        logic               invMem;
        logic               carryIn;
        logic               loadAcc;
        logic               writeMem;
    } aluCtrl_t;

    typedef struct packed {
        logic                 valid;
        logic [AddrWidth-1:0] addr;
        word_t                data;
    } memLoad_t;

    // broadcast from timing to the serial datapath
    typedef struct packed {
        logic                     execute;
        logic [BitCountWidth-1:0] bitCount;
        logic                     advance;
    } bitTime_t;

endpackage

// ==== arithmetic/serialAlu.sv ====
`timescale 1ns/1ps
`default_nettype none

module serialAlu import lvdcPkg::*; (
    input  wire      bo,
    input  wire      rst,
    input  bitTime_t bitTime,
    input  aluCtrl_t aluCtrl,
    input  wire      accBit,
    input  wire      memBit,
    output logic     resultBit
);

    logic carry;
    logic carryUse;
    logic accIn;
    logic memIn;
    logic carryOut;

    assign accIn = accBit ^ aluCtrl.invAcc;
    assign memIn = memBit ^ aluCtrl.invMem;

    // bit 0 takes the preset carry, later bits the flop
    assign carryUse = (bitTime.bitCount == '0) ? aluCtrl.carryIn : carry;
    assign carryOut = (accIn & memIn) | (carryUse & (accIn ^ memIn));

    always_comb begin
        case (aluCtrl.fn)
            FnSum:   resultBit = accIn ^ memIn ^ carryUse;
            FnAnd:   resultBit = accIn & memIn;
            FnXor:   resultBit = accIn ^ memIn;
            default: resultBit = memIn;  // pass memory for CLA
        endcase
    end

    always_ff @(posedge bo) begin
        if (rst) begin
            carry <= 1'b0;
        end else if (bitTime.advance) begin
            carry <= carryOut;  // carry out of bit 25 is dropped
        end
    end

endmodule
`default_nettype wire

// ==== arithmetic/delayLine.sv ====
`timescale 1ns/1ps
`default_nettype none

module delayLine import lvdcPkg::*; (
    input  wire      bo,
    input  wire      rst,
    input  bitTime_t bitTime,
    input  wire      loadAcc,
    input  wire      resultBit,
    output logic     accBit,
    output word_t    accWord
);

    word_t acc;
    word_t accNext;
    logic  lastBit;

    assign accBit  = acc[0];
    assign accNext = {(loadAcc ? resultBit : acc[0]), acc[WordWidth-1:1]};
    assign lastBit = bitTime.advance && (bitTime.bitCount == LastBit);

    always_ff @(posedge bo) begin
        if (rst) begin
            acc     <= '0;
            accWord <= '0;
        end else if (bitTime.advance) begin
            acc <= accNext;
            if (lastBit) begin
                accWord <= accNext;  // word is back in place after 26 shifts
            end
        end
    end

endmodule
`default_nettype wire

// ==== source/timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module timing import lvdcPkg::*; (
    input  wire      bo,
    input  wire      rst,
    input  wire      halt,
    input  wire      syllableStrobe,
    output bitTime_t bitTime,
    output logic     busy,
    output logic     done
);

    logic                     execute;
    logic [BitCountWidth-1:0] bitCount;
    logic                     advance;

    assign advance = execute & ~halt;  // halt freezes the word time
    assign busy    = execute | syllableStrobe;

    always_ff @(posedge bo) begin
        if (rst) begin
            execute  <= 1'b0;
            bitCount <= '0;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!execute) begin
                if (syllableStrobe) begin
                    execute  <= 1'b1;
                    bitCount <= '0;
                end
            end else if (advance) begin
                if (bitCount == LastBit) begin
                    execute  <= 1'b0;  // back to idle
                    bitCount <= '0;
                    done     <= 1'b1;
                end else begin
                    bitCount <= bitCount + 1'b1;
                end
            end
        end
    end

    assign bitTime.execute  = execute;
    assign bitTime.bitCount = bitCount;
    assign bitTime.advance  = advance;

endmodule
`default_nettype wire

// ==== source/transferReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module transferReg import lvdcPkg::*; (
    input  wire       bo,
    input  wire       rst,
    input  wire       din,
    input  wire       dataValid,
    input  wire       busy,
    output syllable_t syllable,
    output logic      syllableStrobe
);

    logic [SyllableWidth-1:0] shiftReg;
    logic [SylCountWidth-1:0] bitCount;
    logic                     take;

    assign take = dataValid & ~busy;

    always_ff @(posedge bo) begin
        if (rst) begin
            bitCount       <= '0;
            syllableStrobe <= 1'b0;
        end else begin
            syllableStrobe <= 1'b0;
            if (take) begin
                if (bitCount == SylCountWidth'(SyllableWidth - 1)) begin
                    bitCount       <= '0;
                    syllableStrobe <= 1'b1;
                end else begin
                    bitCount <= bitCount + 1'b1;
                end
            end
        end
    end

    // lsb first, new bits enter at the top
    always_ff @(posedge bo) begin
        if (take) begin
            shiftReg <= {din, shiftReg[SyllableWidth-1:1]};
        end
    end

    // op code arrives first, so it ends up in the low bits
    assign syllable.opCode = shiftReg[OpWidth-1:0];
    assign syllable.addr   = shiftReg[SyllableWidth-1:OpWidth];

endmodule
`default_nettype wire

// ==== source/opCodeReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module opCodeReg import lvdcPkg::*; (
    input  wire       bo,
    input  wire       rst,
    input  wire       syllableStrobe,
    input  syllable_t syllable,
    output aluCtrl_t  aluCtrl
);

    logic [OpWidth-1:0] opReg;

    always_ff @(posedge bo) begin
        if (rst) begin
            opReg <= '0;  // 0000 runs as a no-op
        end else if (syllableStrobe) begin
            opReg <= syllable.opCode;
        end
    end

    always_comb begin
        aluCtrl = '0;
        aluCtrl.fn = FnSum;
        case (opReg)
            OpAdd: aluCtrl.loadAcc = 1'b1;
            OpSub: begin  // acc + ~mem + 1
                aluCtrl.invMem  = 1'b1;
                aluCtrl.carryIn = 1'b1;
                aluCtrl.loadAcc = 1'b1;
            end
            OpRsu: begin  // mem + ~acc + 1
                aluCtrl.invAcc  = 1'b1;
                aluCtrl.carryIn = 1'b1;
                aluCtrl.loadAcc = 1'b1;
            end
            OpAnd: begin
                aluCtrl.fn      = FnAnd;
                aluCtrl.loadAcc = 1'b1;
            end
            OpXor: begin
                aluCtrl.fn      = FnXor;
                aluCtrl.loadAcc = 1'b1;
            end
            OpCla: begin
                aluCtrl.fn      = FnPass;
                aluCtrl.loadAcc = 1'b1;
            end
            OpSto: aluCtrl.writeMem = 1'b1;  // acc recirculates untouched
            default: ;  // unknown op: full word time, nothing changes
        endcase
    end

endmodule
`default_nettype wire

// ==== source/bufferMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module bufferMemory import lvdcPkg::*; (
    input  wire       bo,
    input  wire       rst,
    input  memLoad_t  memLoad,
    input  wire       syllableStrobe,
    input  syllable_t syllable,
    input  bitTime_t  bitTime,
    input  wire       writeMem,
    input  word_t     accWord,
    output logic      memBit
);

    word_t                mem [MemDepth];
    word_t                bufReg;
    logic [AddrWidth-1:0] addrReg;
    logic                 lastBit;
    logic                 wrEn;
    logic [AddrWidth-1:0] wrAddr;
    word_t                wrData;

    assign lastBit = bitTime.advance && (bitTime.bitCount == LastBit);

    // ground loading only while idle, otherwise the STO path
    always_comb begin
        if (memLoad.valid && !bitTime.execute) begin
            wrEn   = 1'b1;
            wrAddr = memLoad.addr;
            wrData = memLoad.data;
        end else begin
            wrEn   = lastBit && writeMem;
            wrAddr = addrReg;
            wrData = accWord;
        end
    end

    always_ff @(posedge bo) begin
        if (rst) begin
            addrReg <= '0;
        end else if (syllableStrobe) begin
            addrReg <= syllable.addr;
        end
    end

    always_ff @(posedge bo) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    always_ff @(posedge bo) begin
        if (syllableStrobe) begin
            bufReg <= mem[syllable.addr];
        end else if (bitTime.advance) begin
            bufReg <= {1'b0, bufReg[WordWidth-1:1]};  // lsb first
        end
    end

    assign memBit = bufReg[0];

endmodule
`default_nettype wire

// ==== source/lvdc.sv ====
`timescale 1ns/1ps
`default_nettype none

module lvdc import lvdcPkg::*; (
    input  wire      bo,
    input  wire      rst,
    input  logic     din,
    input  wire      dataValid,
    input  wire      halt,
    input  memLoad_t memLoad,
    output word_t    accWord,
    output logic     done
);

    logic      syllableStrobe;
    syllable_t syllable;
    bitTime_t  bitTime;
    logic      busy;
    aluCtrl_t  aluCtrl;
    logic      memBit;
    logic      accBit;
    logic      resultBit;

    timing i_timing (
        .bo(bo),
        .rst(rst),
        .halt(halt),
        .syllableStrobe(syllableStrobe),
        .bitTime(bitTime),
        .busy(busy),
        .done(done)
    );

    transferReg i_transferReg (
        .bo(bo),
        .rst(rst),
        .din(din),
        .dataValid(dataValid),
        .busy(busy),
        .syllable(syllable),
        .syllableStrobe(syllableStrobe)
    );

    opCodeReg i_opCodeReg (
        .bo(bo),
        .rst(rst),
        .syllableStrobe(syllableStrobe),
        .syllable(syllable),
        .aluCtrl(aluCtrl)
    );

    serialAlu i_serialAlu (
        .bo(bo),
        .rst(rst),
        .bitTime(bitTime),
        .aluCtrl(aluCtrl),
        .accBit(accBit),
        .memBit(memBit),
        .resultBit(resultBit)
    );

    delayLine i_delayLine (
        .bo(bo),
        .rst(rst),
        .bitTime(bitTime),
        .loadAcc(aluCtrl.loadAcc),
        .resultBit(resultBit),
        .accBit(accBit),
        .accWord(accWord)
    );

    bufferMemory i_bufferMemory (
        .bo(bo),
        .rst(rst),
        .memLoad(memLoad),
        .syllableStrobe(syllableStrobe),
        .syllable(syllable),
        .bitTime(bitTime),
        .writeMem(aluCtrl.writeMem),
        .accWord(accWord),  // STO source
        .memBit(memBit)
    );

endmodule
`default_nettype wire

// ==== sim/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
    output logic bo
);

    initial begin
        bo = 1'b0;
        forever begin
            #50 bo = ~bo;  // 100 ns period
        end
    end

endmodule

// ==== sim/tbLvdc.sv ====
`timescale 1ns/1ps

module tbLvdc import lvdcPkg::*; ();

    localparam int          DriveDelay  = 1;
    localparam int          DoneTimeout = 200;
    localparam int          DoneLatency = WordWidth + 1;  // strobe cycle plus one cycle per bit
    localparam int          JunkCycles  = 15;  // well inside the shortest word time
    localparam int unsigned Seed        = 32'h6ef22c3f;

    logic     bo;
    logic     rst;
    logic     din;
    logic     dataValid;
    logic     halt;
    memLoad_t memLoad;
    word_t    accWord;
    logic     done;

    word_t              modelMem [MemDepth];
    word_t              modelAcc;
    word_t              expQ [$];
    logic [OpWidth-1:0] keptOps [7];
    int                 errors;
    int                 doneCount;
    int                 instrCount;
    int unsigned        seedVal;
    bit                 haltEnable;
    bit                 junkEnable;

    clockGen i_clockGen (
        .bo(bo)
    );

    lvdc i_lvdc (
        .bo(bo),
        .rst(rst),
        .din(din),
        .dataValid(dataValid),
        .halt(halt),
        .memLoad(memLoad),
        .accWord(accWord),
        .done(done)
    );

    // model of one instruction, returns the accumulator after it
    function automatic word_t refExecute(input logic [OpWidth-1:0] op,
                                         input logic [AddrWidth-1:0] addr);
        word_t m;
        m = modelMem[addr];
        case (op)
            OpSub: modelAcc = modelAcc - m;
            OpAnd: modelAcc = modelAcc & m;
            OpAdd: modelAcc = modelAcc + m;
            OpXor: modelAcc = modelAcc ^ m;
            OpSto: modelMem[addr] = modelAcc;
            OpRsu: modelAcc = m - modelAcc;
            OpCla: modelAcc = m;
            default: ;
        endcase
        return modelAcc;
    endfunction

    task automatic finishRun();
        $display("errors: %0d, done pulses: %0d, instructions: %0d",
                 errors, doneCount, instrCount);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic loadWord(input logic [AddrWidth-1:0] addr, input word_t data);
        memLoad.valid = 1'b1;
        memLoad.addr  = addr;
        memLoad.data  = data;
        modelMem[addr] = data;
        @(posedge bo);
        #DriveDelay;
        memLoad.valid = 1'b0;
    endtask

    // lsb first, op code then address, random idle gaps
    task automatic sendSyllable(input syllable_t syl);
        logic [SyllableWidth-1:0] bits;
        bits = {syl.addr, syl.opCode};
        for (int i = 0; i < SyllableWidth; i++) begin
            if ($urandom_range(1, 0) == 1) begin
                dataValid = 1'b0;
                din       = $urandom_range(1, 0);
                @(posedge bo);
                #DriveDelay;
            end
            dataValid = 1'b1;
            din       = bits[i];
            @(posedge bo);
            #DriveDelay;
        end
        dataValid = 1'b0;
    endtask

    task automatic waitDone();
        int waited;
        int haltCycles;
        waited     = 0;
        haltCycles = 0;
        while (!done && waited < DoneTimeout) begin
            if (junkEnable && waited < JunkCycles) begin
                dataValid = 1'b1;  // core is busy, these bits must be dropped
                din       = $urandom_range(1, 0);
            end else begin
                dataValid = 1'b0;
            end
            // first cycle is the strobe cycle, halt only stretches execute
            halt = (haltEnable && waited > 0) ? ($urandom_range(2, 0) == 0) : 1'b0;
            if (halt) begin
                haltCycles++;
            end
            @(posedge bo);
            #DriveDelay;
            waited++;
        end
        halt      = 1'b0;
        dataValid = 1'b0;
        if (!done) begin
            $display("timeout at %0t: no done within %0d cycles", $time, DoneTimeout);
            errors++;
            finishRun();
        end else if (waited != DoneLatency + haltCycles) begin
            $display("Fail %0t done latency expected %0d actual %0d",
                     $time, DoneLatency + haltCycles, waited);
            errors++;
        end
    endtask

    task automatic runInstr(input logic [OpWidth-1:0] op, input logic [AddrWidth-1:0] addr);
        syllable_t syl;
        syl.opCode = op;
        syl.addr   = addr;
        expQ.push_back(refExecute(op, addr));
        instrCount++;
        sendSyllable(syl);
        waitDone();
    endtask

    task automatic checkIdle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge bo);
            #DriveDelay;
            if (done !== 1'b0) begin
                $display("Fail %0t done expected 0 actual %b", $time, done);
                errors++;
            end
            if (accWord !== '0) begin
                $display("Fail %0t accWord expected %h actual %h", $time, word_t'(0), accWord);
                errors++;
            end
        end
    endtask

    // one comparison per done pulse
    always @(negedge bo) begin
        word_t expected;
        if (!rst && done) begin
            doneCount++;
            if (expQ.size() == 0) begin
                $display("done pulsed at %0t with no instruction pending", $time);
                errors++;
            end else begin
                expected = expQ.pop_front();
                if (accWord !== expected) begin
                    $display("Fail %0t accWord expected %h actual %h",
                             $time, expected, accWord);
                    errors++;
                end
            end
        end
    end

    initial begin
        seedVal    = $urandom(Seed);
        rst        = 1'b1;
        din        = 1'b0;
        dataValid  = 1'b0;
        halt       = 1'b0;
        memLoad    = '0;
        modelAcc   = '0;
        errors     = 0;
        doneCount  = 0;
        instrCount = 0;
        haltEnable = 1'b0;
        junkEnable = 1'b0;
        keptOps    = '{OpSub, OpAnd, OpAdd, OpXor, OpSto, OpRsu, OpCla};

        repeat (10) @(posedge bo);
        #DriveDelay;
        rst = 1'b0;

        checkIdle(30);

        for (int a = 0; a < MemDepth; a++) begin
            loadWord(AddrWidth'(a), word_t'($urandom));
        end
        loadWord(10, '1);  // all ones for overflow
        loadWord(11, 26'd1);
        loadWord(12, 26'd5);
        loadWord(13, 26'd7);

        // each kept op on random words
        runInstr(OpCla, 20);
        runInstr(OpAdd, 21);
        runInstr(OpSub, 22);
        runInstr(OpRsu, 23);
        runInstr(OpAnd, 24);
        runInstr(OpXor, 25);

        // wrap at 2^26
        runInstr(OpCla, 10);
        runInstr(OpAdd, 11);
        runInstr(OpCla, 12);
        runInstr(OpSub, 13);
        runInstr(OpCla, 13);
        runInstr(OpRsu, 12);

        // store and read back
        runInstr(OpCla, 30);
        runInstr(OpAdd, 31);
        runInstr(OpSto, 40);
        runInstr(OpCla, 41);
        runInstr(OpCla, 40);

        // unused op codes
        runInstr(4'b0001, 50);
        runInstr(4'b0000, 51);
        runInstr(4'b0100, 52);

        haltEnable = 1'b1;
        junkEnable = 1'b1;
        for (int n = 0; n < 24; n++) begin
            runInstr(keptOps[$urandom_range(6, 0)], AddrWidth'($urandom_range(MemDepth - 1, 0)));
        end
        runInstr(4'b1000, 60);
        runInstr(OpCla, 40);

        repeat (3) @(posedge bo);
        if (expQ.size() != 0) begin
            $display("%0d instructions finished without a done pulse", expQ.size());
            errors++;
        end
        if (doneCount != instrCount) begin
            $display("done pulsed %0d times for %0d instructions", doneCount, instrCount);
            errors++;
        end
        finishRun();
    end

endmodule

// ==== verilog.f ====
common/lvdcPkg.sv
arithmetic/serialAlu.sv
arithmetic/delayLine.sv
source/timing.sv
source/transferReg.sv
source/opCodeReg.sv
source/bufferMemory.sv
source/lvdc.sv
sim/clockGen.sv
sim/tbLvdc.sv
